// File: src/bt_reg_pkg.sv
/*
	Host register map for the bridge, byte addressed over APB.
	Status is read only; a write to it is accepted and has no effect.
*/
`default_nettype none

package bt_reg_pkg;

	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;

	// Register offsets
	localparam reg_addr_t ctrl_addr = 8'h00;
	localparam reg_addr_t txdata_addr = 8'h04;
	localparam reg_addr_t rxdata_addr = 8'h08;
	localparam reg_addr_t status_addr = 8'h0C;
	localparam reg_addr_t divider_addr = 8'h10;
	localparam reg_addr_t gap_addr = 8'h14;

	// Status word layout, count occupies 8 bits from rsp_count_lsb
	localparam int unsigned busy_bit = 0;
	localparam int unsigned response_ready_bit = 1;
	localparam int unsigned cmd_full_bit = 2;
	localparam int unsigned rsp_empty_bit = 3;
	localparam int unsigned rsp_count_lsb = 8;

endpackage

`default_nettype wire

// File: src/bt_link_pkg.sv
/*
	Serial link types: 8N1 framing, one stop bit, no parity.
	Divider values below 2 are not supported by the receiver.
*/
`default_nettype none

package bt_link_pkg;

	typedef logic [7:0] link_byte_t;
	typedef logic [15:0] divider_t;
	typedef logic [15:0] gap_t;

	// Power-up link settings
	localparam divider_t divider_reset = 16'd16;
	localparam gap_t gap_reset = 16'd4;

	// Byte that closes a module reply
	localparam link_byte_t line_end = 8'h0A;

	typedef enum logic [1:0] {
		idle,
		load,
		send,
		rest
	} seq_state_t;

endpackage

`default_nettype wire

// File: src/host_link_if.sv
/*
	Control, command and response signals between the register decoder
	and the transmit and receive blocks. All signals are in the one clock domain.
*/
`timescale 1ns/1ps
`default_nettype none

interface host_link_if;

	// Decoder side
	logic cmd_push;
	bt_link_pkg::link_byte_t cmd_byte;
	logic start;
	bt_link_pkg::divider_t divider;
	bt_link_pkg::gap_t gap;
	logic rsp_pop;

	// Sequencer flags
	logic cmd_full;
	logic busy;

	// Collector side
	bt_link_pkg::link_byte_t rsp_byte;
	logic rsp_empty;
	logic [7:0] rsp_count;
	logic response_ready;

	modport decoder (
		output cmd_push, cmd_byte, start, divider, gap, rsp_pop,
		input cmd_full, busy, rsp_byte, rsp_empty, rsp_count, response_ready
	);

	modport sequencer (
		input cmd_push, cmd_byte, start, divider, gap,
		output cmd_full, busy
	);

	modport collector (
		input start, divider, rsp_pop,
		output rsp_byte, rsp_empty, rsp_count, response_ready
	);

endinterface

`default_nettype wire

// File: src/byte_fifo.sv
/*
	Single clock byte FIFO, head byte visible without a pop.
	FIFO_DEPTH may be any value from 2 to 255, power of two or not.
	Push when full and pop when empty are ignored.
*/
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic reset,
	input logic push,
	input logic pop,
	input bt_link_pkg::link_byte_t push_byte,
	output bt_link_pkg::link_byte_t head_byte,
	output logic full,
	output logic empty,
	output logic [7:0] count
);

	localparam int ptr_width = (FIFO_DEPTH > 2) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [ptr_width-1:0] last_ptr = ptr_width'(FIFO_DEPTH - 1);
	localparam logic [7:0] depth_count = 8'(FIFO_DEPTH);

	bt_link_pkg::link_byte_t mem [FIFO_DEPTH];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = (count == depth_count);
	assign empty = (count == 8'd0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign head_byte = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= push_byte;
	end

	// Pointers wrap at the last slot so odd depths work
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 8'd0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 8'd1;
				2'b01: count <= count - 8'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/apb_decode.sv
/*
	APB slave with pready tied high, so every transfer is two cycles.
	Side effects happen once, in the access cycle. Unmapped offsets raise
	pslverr and read zero. A read of rxdata pops the response FIFO.
*/
`timescale 1ns/1ps
`default_nettype none

module apb_decode (
	input logic clock,
	input logic reset,
	input bt_reg_pkg::reg_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input bt_reg_pkg::reg_data_t pwdata,
	output bt_reg_pkg::reg_data_t prdata,
	output logic pready,
	output logic pslverr,
	host_link_if.decoder link
);

	logic access;
	logic write_access;
	logic read_access;
	logic mapped;
	bt_link_pkg::divider_t divider_q;
	bt_link_pkg::gap_t gap_q;
	bt_reg_pkg::reg_data_t status;

	assign access = psel && penable;
	assign write_access = access && pwrite;
	assign read_access = access && !pwrite;
	assign pready = 1'b1;
	assign pslverr = access && !mapped;

	// Single cycle strobes towards the link blocks
	assign link.cmd_push = write_access && (paddr == bt_reg_pkg::txdata_addr);
	assign link.cmd_byte = pwdata[7:0];
	assign link.start = write_access && (paddr == bt_reg_pkg::ctrl_addr) && pwdata[0];
	assign link.rsp_pop = read_access && (paddr == bt_reg_pkg::rxdata_addr) && !link.rsp_empty;
	assign link.divider = divider_q;
	assign link.gap = gap_q;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			divider_q <= bt_link_pkg::divider_reset;
			gap_q <= bt_link_pkg::gap_reset;
		end
		else if (write_access)
		begin
			if (paddr == bt_reg_pkg::divider_addr)
				divider_q <= pwdata[$bits(bt_link_pkg::divider_t)-1:0];
			if (paddr == bt_reg_pkg::gap_addr)
				gap_q <= pwdata[$bits(bt_link_pkg::gap_t)-1:0];
		end
	end

	always_comb
	begin
		status = '0;
		status[bt_reg_pkg::busy_bit] = link.busy;
		status[bt_reg_pkg::response_ready_bit] = link.response_ready;
		status[bt_reg_pkg::cmd_full_bit] = link.cmd_full;
		status[bt_reg_pkg::rsp_empty_bit] = link.rsp_empty;
		status[bt_reg_pkg::rsp_count_lsb +: 8] = link.rsp_count;
	end

	// Address decode and read mux
	always_comb
	begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			bt_reg_pkg::ctrl_addr, bt_reg_pkg::txdata_addr: ;
			bt_reg_pkg::rxdata_addr:
				if (read_access && !link.rsp_empty)
					prdata = bt_reg_pkg::reg_data_t'(link.rsp_byte);
			bt_reg_pkg::status_addr:
				if (read_access)
					prdata = status;
			bt_reg_pkg::divider_addr:
				if (read_access)
					prdata = bt_reg_pkg::reg_data_t'(divider_q);
			bt_reg_pkg::gap_addr:
				if (read_access)
					prdata = bt_reg_pkg::reg_data_t'(gap_q);
			default:
				mapped = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/link_sequencer.sv
/*
	Command sender: one load cycle, ten bit periods (start, 8 data LSB first,
	stop), then gap rest cycles per byte. Divider must be nonzero. Start is
	ignored while busy; a start with an empty FIFO gives a one cycle busy.
*/
`timescale 1ns/1ps
`default_nettype none

module link_sequencer #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic reset,
	output logic txd,
	host_link_if.sequencer link
);

	bt_link_pkg::seq_state_t state;
	bt_link_pkg::seq_state_t after_byte;
	bt_link_pkg::link_byte_t head_byte;
	bt_link_pkg::divider_t bit_timer;
	bt_link_pkg::gap_t gap_timer;
	logic [3:0] bit_index;
	logic [9:0] frame;
	logic cmd_empty;
	logic bit_done;

	byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_cmd_fifo (
		.clock(clock),
		.reset(reset),
		.push(link.cmd_push),
		.pop(state == bt_link_pkg::load),
		.push_byte(link.cmd_byte),
		.head_byte(head_byte),
		.full(link.cmd_full),
		.empty(cmd_empty),
		.count()
	);

	assign link.busy = (state != bt_link_pkg::idle);
	assign bit_done = (bit_timer == link.divider - bt_link_pkg::divider_t'(1));
	assign txd = (state == bt_link_pkg::send) ? frame[0] : 1'b1;

	// Next byte or back to idle once the queue has drained
	always_comb
	begin
		if (cmd_empty)
			after_byte = bt_link_pkg::idle;
		else
			after_byte = bt_link_pkg::load;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= bt_link_pkg::idle;
			bit_timer <= '0;
			bit_index <= 4'd0;
			gap_timer <= '0;
		end
		else
		begin
			case (state)
				bt_link_pkg::idle:
					if (link.start)
						state <= bt_link_pkg::load;
				bt_link_pkg::load:
				begin
					bit_timer <= '0;
					bit_index <= 4'd0;
					state <= cmd_empty ? bt_link_pkg::idle : bt_link_pkg::send;
				end
				bt_link_pkg::send:
					if (bit_done)
					begin
						bit_timer <= '0;
						bit_index <= bit_index + 4'd1;
						gap_timer <= '0;
						// Stop bit finished; a zero gap skips the rest state
						if (bit_index == 4'd9)
							state <= (link.gap == '0) ? after_byte : bt_link_pkg::rest;
					end
					else
						bit_timer <= bit_timer + bt_link_pkg::divider_t'(1);
				bt_link_pkg::rest:
					if (gap_timer == link.gap - bt_link_pkg::gap_t'(1))
						state <= after_byte;
					else
						gap_timer <= gap_timer + bt_link_pkg::gap_t'(1);
				default:
					state <= bt_link_pkg::idle;
			endcase
		end
	end

	// Frame shifts out LSB first, idle level refills from the top
	always_ff @(posedge clock)
	begin
		if (state == bt_link_pkg::load)
			frame <= {1'b1, head_byte, 1'b0};
		else if (state == bt_link_pkg::send && bit_done)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

`default_nettype wire

// File: src/response_collector.sv
/*
	UART receiver, 8N1, no framing or parity checks. Divider must be 2 or more.
	A start bit that is high again at mid-period is taken as noise.
	Bytes arriving while the response FIFO is full are dropped.
*/
`timescale 1ns/1ps
`default_nettype none

module response_collector #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic reset,
	input logic rxd,
	host_link_if.collector link
);

	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	logic rx_active;
	logic first_sample;
	logic sample_tick;
	logic rx_push;
	logic rsp_full;
	logic [3:0] bit_index;
	bt_link_pkg::divider_t bit_timer;
	bt_link_pkg::divider_t sample_point;
	bt_link_pkg::link_byte_t rx_data;

	byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rsp_fifo (
		.clock(clock),
		.reset(reset),
		.push(rx_push),
		.pop(link.rsp_pop),
		.push_byte(rx_data),
		.head_byte(link.rsp_byte),
		.full(rsp_full),
		.empty(link.rsp_empty),
		.count(link.rsp_count)
	);

	// Half a period to the start bit middle, then whole periods
	assign sample_point = first_sample ? (link.divider >> 1) - bt_link_pkg::divider_t'(1)
		: link.divider - bt_link_pkg::divider_t'(1);
	assign sample_tick = rx_active && (bit_timer == sample_point);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
			rx_active <= 1'b0;
			first_sample <= 1'b0;
			bit_index <= 4'd0;
			bit_timer <= '0;
			rx_push <= 1'b0;
			link.response_ready <= 1'b0;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
			rx_push <= 1'b0;
			if (!rx_active)
			begin
				if (rxd_prev && !rxd_sync)
				begin
					rx_active <= 1'b1;
					first_sample <= 1'b1;
					bit_index <= 4'd0;
					bit_timer <= '0;
				end
			end
			else if (sample_tick)
			begin
				bit_timer <= '0;
				first_sample <= 1'b0;
				bit_index <= bit_index + 4'd1;
				if (bit_index == 4'd0 && rxd_sync)
					rx_active <= 1'b0;
				else if (bit_index == 4'd9)
				begin
					rx_active <= 1'b0;
					rx_push <= 1'b1;
				end
			end
			else
				bit_timer <= bit_timer + bt_link_pkg::divider_t'(1);
			// Reply complete once a stored byte is the line end
			if (link.start)
				link.response_ready <= 1'b0;
			else if (rx_push && !rsp_full && rx_data == bt_link_pkg::line_end)
				link.response_ready <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (sample_tick && bit_index >= 4'd1 && bit_index <= 4'd8)
			rx_data <= {rxd_sync, rx_data[7:1]};
	end

endmodule

`default_nettype wire

// File: src/bt_bridge.sv
/*
	APB to serial Bluetooth module bridge, single clock domain.
	Commands go out on fpga_txd; the reply on fpga_rxd ends with a line feed.
*/
`timescale 1ns/1ps
`default_nettype none

module bt_bridge #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic reset,
	input bt_reg_pkg::reg_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input bt_reg_pkg::reg_data_t pwdata,
	output bt_reg_pkg::reg_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic fpga_txd,
	input logic fpga_rxd
);

	host_link_if u_link ();

	apb_decode u_apb_decode (
		.clock(clock),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.link(u_link.decoder)
	);

	link_sequencer #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_link_sequencer (
		.clock(clock),
		.reset(reset),
		.txd(fpga_txd),
		.link(u_link.sequencer)
	);

	response_collector #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_response_collector (
		.clock(clock),
		.reset(reset),
		.rxd(fpga_rxd),
		.link(u_link.collector)
	);

endmodule

`default_nettype wire

// File: test/tb_bt_bridge.sv
/*
	Testbench for bt_bridge with fpga_txd looped back to fpga_rxd,
	so every reply is the echo of the command bytes sent.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_bt_bridge;

	localparam int fifo_depth = 16;
	// Overflow echo is the longest test, about 3k cycles at divider 16
	localparam int timeout_cycles = 200000;
	localparam logic [7:0] line_end = 8'h0A;
	localparam logic [7:0] unmapped_addr = 8'h18;

	logic clock;
	logic reset;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic fpga_txd;
	logic fpga_rxd;

	logic [15:0] lfsr_state;
	logic [7:0] rsp_model[$];
	logic [7:0] last_sent[$];
	int cycle_count;
	int check_count;
	int error_count;
	int test_errors;
	int test_count;

	bt_bridge #(
		.FIFO_DEPTH(fifo_depth)
	) u_bt_bridge (
		.clock(clock),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fpga_txd(fpga_txd),
		.fpga_rxd(fpga_rxd)
	);

	// Serial loopback
	assign fpga_rxd = fpga_txd;

	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		do
		begin
			for (int i = 0; i < 8; i++)
			begin
				lfsr_state = lfsr_next(lfsr_state);
				b = {lfsr_state[0], b[7:1]};
			end
		end
		while (b == line_end);
		return b;
	endfunction

	// Status word per the register map, response side taken from the model queue
	function automatic logic [31:0] expected_status(input logic busy, input logic ready,
		input logic cmd_full);
		logic [31:0] word;
		word = '0;
		word[0] = busy;
		word[1] = ready;
		word[2] = cmd_full;
		word[3] = (rsp_model.size() == 0);
		word[15:8] = 8'(rsp_model.size());
		return word;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			$display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("Test %-16s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
			test_errors);
		test_errors = 0;
	endtask

	// Setup cycle then access cycle, sampled mid access cycle
	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clock);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clock);
		penable = 1'b1;
		#1;
		rdata = prdata;
		err = pslverr;
		check_value("pready", 32'd1, {31'd0, pready});
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] d;
		logic e;
		apb_access(1'b1, addr, data, d, e);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		logic e;
		apb_access(1'b0, addr, 32'd0, data, e);
	endtask

	task automatic push_byte(input logic [7:0] b, input logic keep);
		apb_write(bt_reg_pkg::txdata_addr, {24'd0, b});
		if (keep)
			rsp_model.push_back(b);
	endtask

	task automatic push_command(input int n_random);
		logic [7:0] b;
		last_sent.delete();
		for (int i = 0; i < n_random; i++)
		begin
			b = random_byte();
			last_sent.push_back(b);
			push_byte(b, 1'b1);
		end
		last_sent.push_back(line_end);
		push_byte(line_end, 1'b1);
	endtask

	// Poll until the send is over and the line end has been stored
	task automatic wait_reply();
		logic [31:0] st;
		apb_read(bt_reg_pkg::status_addr, st);
		while (st[0] || !st[1])
			apb_read(bt_reg_pkg::status_addr, st);
	endtask

	task automatic drain_and_check(input string name);
		logic [31:0] st;
		logic [31:0] data;
		logic [7:0] exp;
		apb_read(bt_reg_pkg::status_addr, st);
		check_value({name, " status"}, expected_status(1'b0, 1'b1, 1'b0), st);
		while (rsp_model.size() > 0)
		begin
			exp = rsp_model.pop_front();
			apb_read(bt_reg_pkg::rxdata_addr, data);
			check_value({name, " rxdata"}, {24'd0, exp}, data);
		end
		apb_read(bt_reg_pkg::status_addr, st);
		check_value({name, " drained"}, expected_status(1'b0, 1'b1, 1'b0), st);
	endtask

	initial
	begin
		logic [31:0] data;
		logic err;
		clock = 1'b0;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		lfsr_state = 16'd31500;
		cycle_count = 0;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		test_count = 0;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		// Serial line idles high
		check_value("reset txd", 32'd1, {31'd0, fpga_txd});
		apb_read(bt_reg_pkg::status_addr, data);
		check_value("reset status", expected_status(1'b0, 1'b0, 1'b0), data);
		apb_read(bt_reg_pkg::divider_addr, data);
		check_value("reset divider", 32'd16, data);
		apb_read(bt_reg_pkg::gap_addr, data);
		check_value("reset gap", 32'd4, data);
		finish_test("reset");

		apb_write(bt_reg_pkg::divider_addr, 32'd12);
		apb_access(1'b0, bt_reg_pkg::divider_addr, 32'd0, data, err);
		check_value("regs divider", 32'd12, data);
		check_value("regs divider pslverr", 32'd0, {31'd0, err});
		apb_write(bt_reg_pkg::gap_addr, 32'd7);
		apb_read(bt_reg_pkg::gap_addr, data);
		check_value("regs gap", 32'd7, data);
		apb_access(1'b0, unmapped_addr, 32'd0, data, err);
		check_value("regs unmapped read pslverr", 32'd1, {31'd0, err});
		check_value("regs unmapped rdata", 32'd0, data);
		apb_access(1'b1, unmapped_addr, 32'hFFFF_FFFF, data, err);
		check_value("regs unmapped write pslverr", 32'd1, {31'd0, err});
		apb_write(bt_reg_pkg::divider_addr, 32'd16);
		apb_write(bt_reg_pkg::gap_addr, 32'd4);
		finish_test("registers");

		push_command(5);
		apb_write(bt_reg_pkg::ctrl_addr, 32'd1);
		wait_reply();
		drain_and_check("echo");
		finish_test("echo");

		// Same bytes again on a faster link with no rest gap
		apb_write(bt_reg_pkg::divider_addr, 32'd8);
		apb_write(bt_reg_pkg::gap_addr, 32'd0);
		foreach (last_sent[i])
			push_byte(last_sent[i], 1'b1);
		apb_write(bt_reg_pkg::ctrl_addr, 32'd1);
		wait_reply();
		drain_and_check("link settings");
		finish_test("link settings");

		// FIFO fills with line end as its last entry, two more pushes are dropped
		push_command(fifo_depth - 1);
		push_byte(random_byte(), 1'b0);
		push_byte(random_byte(), 1'b0);
		apb_read(bt_reg_pkg::status_addr, data);
		check_value("overflow cmd_full", 32'd1, {31'd0, data[2]});
		apb_write(bt_reg_pkg::ctrl_addr, 32'd1);
		wait_reply();
		drain_and_check("overflow");
		finish_test("overflow");

		push_command(3);
		apb_write(bt_reg_pkg::ctrl_addr, 32'd1);
		apb_read(bt_reg_pkg::status_addr, data);
		check_value("start busy flag", 32'd1, {31'd0, data[0]});
		apb_write(bt_reg_pkg::ctrl_addr, 32'd1);
		wait_reply();
		drain_and_check("start busy");
		finish_test("start while busy");

		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: bt_bridge.f
src/bt_reg_pkg.sv
src/bt_link_pkg.sv
src/host_link_if.sv
src/byte_fifo.sv
src/apb_decode.sv
src/link_sequencer.sv
src/response_collector.sv
src/bt_bridge.sv
test/tb_bt_bridge.sv

// File: Makefile
# Verilator build and run for the bt_bridge testbench

SIM = obj_dir/Vtb_bt_bridge

.PHONY: all build lint clean

all: build
	./$(SIM) > sim.log 2>&1; cat sim.log
	@grep -q "Finished with no errors" sim.log

build:
	verilator --binary --timing -f bt_bridge.f --top-module tb_bt_bridge -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timing -f bt_bridge.f --top-module bt_bridge

clean:
	rm -rf obj_dir sim.log
